/* Bender.yml */
package:
  name: memwb_backend

sources:
  - logic/cpuPkg.sv
  - logic/memPortIf.sv
  - logic/memArbiter.sv
  - logic/unifiedMemory.sv
  - logic/fetchPort.sv
  - logic/memWbPipeReg.sv
  - logic/writeBack.sv
  - logic/memWbTop.sv
  - target: simulation
    files:
      - verif/memWbTb.sv

/* all.f */
logic/cpuPkg.sv
logic/memPortIf.sv
logic/memArbiter.sv
logic/unifiedMemory.sv
logic/fetchPort.sv
logic/memWbPipeReg.sv
logic/writeBack.sv
logic/memWbTop.sv
verif/memWbTb.sv

/* logic/cpuPkg.sv */
//////////////////////////////
// Shared definitions for the CPU back end
// Word, memory and register file sizes
// Write-back control bundle as a packed union
//////////////////////////////
package cpuPkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int dataWidth    = 16;   // Machine word
  localparam int memDepth     = 256;  // Words in the unified memory
  localparam int memAddrWidth = 8;    // Low address bits used by memory
  localparam int regCount     = 16;   // Architectural registers
  localparam int regAddrWidth = 4;    // Register index width
  localparam int wbCtrlWidth  = regAddrWidth + 4;  // Bundle width, 8 bits

  //////////////////////////////
  // Write-back control bundle
  //////////////////////////////
  // Field order follows the bundle bits, MSB first
  typedef struct packed {
    logic [regAddrWidth-1:0] regRd;  // Destination register
    logic                    regWrite;  // Register file write enable
    logic                    memToReg;  // Load result goes to register
    logic                    hlt;       // Halt instruction
    logic                    pcs;       // Next PC goes to register
  } wbFieldsT;

  // Same 8 bits seen as a raw word between stages or as decoded fields
  typedef union packed {
    logic [wbCtrlWidth-1:0] raw;
    wbFieldsT               fields;
  } wbCtrlT;

endpackage

/* logic/fetchPort.sv */
//////////////////////////////
// Instruction fetch requester
// Registers the granted word
// Valid pulse and stall level
//////////////////////////////
`timescale 1ns/1ns

module fetchPort (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fetchReq,    // Fetch wanted at fetchPc
  input  logic [cpuPkg::dataWidth-1:0] fetchPc,     // Instruction address
  memPortIf.requester                  port,        // To the arbiter
  output logic [cpuPkg::dataWidth-1:0] fetchInstr,  // Last fetched instruction
  output logic                         fetchValid,  // One cycle after a granted fetch
  output logic                         fetchStall   // Waiting on the data port
);

  logic fetchDone;  // Request granted this cycle

  // Read-only requester, retried every cycle while held
  assign port.req    = fetchReq;
  assign port.we     = 1'b0;
  assign port.addr   = fetchPc;
  assign port.wrData = '0;

  assign fetchDone  = fetchReq & port.gnt;
  assign fetchStall = fetchReq & ~port.gnt;  // Combinational, no reset gating

  //////////////////////////////
  // Instruction capture
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (fetchDone) begin
      fetchInstr <= port.rdData;  // Payload, holds between fetches
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetchValid <= 1'b0;
    end else begin
      fetchValid <= fetchDone;  // Single pulse per grant
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Fetch side must never reach the memory write path
  assert property (@(posedge clk) disable iff (rst) !(port.gnt && port.we))
    else $error("fetchPort: write from fetch port");

endmodule

/* logic/memArbiter.sv */
//////////////////////////////
// Fixed priority memory arbiter
// Data port beats fetch port
// Winner drives the single memory
//////////////////////////////
`timescale 1ns/1ns

module memArbiter (
  input  logic                            clk,        // Only for checks
  memPortIf.arbiter                       dataPort,   // Load and store requests
  memPortIf.arbiter                       instrPort,  // Instruction fetch requests
  output logic                            memWe,      // Memory write strobe
  output logic [cpuPkg::memAddrWidth-1:0] memAddr,    // Memory word address
  output logic [cpuPkg::dataWidth-1:0]    memWrData,  // Memory write word
  input  logic [cpuPkg::dataWidth-1:0]    memRdData   // Memory read word
);

  //////////////////////////////
  // Grants
  //////////////////////////////
  assign dataPort.gnt  = dataPort.req;                   // Data never stalls
  assign instrPort.gnt = instrPort.req & ~dataPort.req;  // Fetch only when data idle

  //////////////////////////////
  // Route winner to memory
  //////////////////////////////
  always_comb begin
    if (dataPort.gnt) begin
      memAddr   = dataPort.addr[cpuPkg::memAddrWidth-1:0];
      memWrData = dataPort.wrData;
      memWe     = dataPort.we;
    end else begin
      // Fetch address also drives an idle memory, harmless since no write
      memAddr   = instrPort.addr[cpuPkg::memAddrWidth-1:0];
      memWrData = instrPort.wrData;
      memWe     = instrPort.gnt & instrPort.we;
    end
  end

  // One read word shared by both requesters
  assign dataPort.rdData  = memRdData;
  assign instrPort.rdData = memRdData;

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Only one requester owns the memory in a cycle
  assert property (@(posedge clk) !(dataPort.gnt && instrPort.gnt))
    else $error("memArbiter: both ports granted");

  // A grant always answers a request from that port
  assert property (@(posedge clk)
                   (dataPort.gnt -> dataPort.req) && (instrPort.gnt -> instrPort.req))
    else $error("memArbiter: grant without request");

endmodule

/* logic/memPortIf.sv */
//////////////////////////////
// Memory request port of one requester
// Request side and arbiter side modports
//////////////////////////////
`timescale 1ns/1ns

interface memPortIf;

  logic                         req;     // Access wanted this cycle
  logic                         we;      // Access is a write
  logic [cpuPkg::dataWidth-1:0] addr;    // Word address, low bits used
  logic [cpuPkg::dataWidth-1:0] wrData;  // Store word
  logic                         gnt;     // Access wins the memory this cycle
  logic [cpuPkg::dataWidth-1:0] rdData;  // Combinational read word

  // Side that asks for the memory
  modport requester (
    output req, we, addr, wrData,
    input  gnt, rdData
  );

  // Side that grants it
  modport arbiter (
    input  req, we, addr, wrData,
    output gnt, rdData
  );

endinterface

/* logic/memWbPipeReg.sv */
//////////////////////////////
// MEM/WB pipeline register
// Next PC, ALU result, load word, control bundle
// Flush clears all but the next PC
//////////////////////////////
`timescale 1ns/1ns

module memWbPipeReg (
  input  logic                         clk,
  input  logic                         rst,           // Clears everything
  input  logic                         flush,         // Kills the current bundle
  input  logic [cpuPkg::dataWidth-1:0] exMemPcNext,   // Next PC from EX/MEM
  input  logic [cpuPkg::dataWidth-1:0] exMemAluOut,   // ALU result from EX/MEM
  input  logic [cpuPkg::dataWidth-1:0] memData,       // Load word from memory
  input  cpuPkg::wbCtrlT               exMemWbCtrl,   // Write-back controls
  output logic [cpuPkg::dataWidth-1:0] memWbPcNext,
  output logic [cpuPkg::dataWidth-1:0] memWbAluOut,
  output logic [cpuPkg::dataWidth-1:0] memWbMemData,
  output cpuPkg::wbCtrlT               memWbWbCtrl
);

  logic clr;  // Flush or reset

  assign clr = flush | rst;

  //////////////////////////////
  // Next PC
  //////////////////////////////
  // Survives a flush
  always_ff @(posedge clk) begin
    if (rst) begin
      memWbPcNext <= '0;
    end else begin
      memWbPcNext <= exMemPcNext;
    end
  end

  //////////////////////////////
  // Data path
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (clr) begin
      memWbAluOut  <= '0;
      memWbMemData <= '0;
    end else begin
      memWbAluOut  <= exMemAluOut;
      memWbMemData <= memData;  // Load word captured at the same edge
    end
  end

  //////////////////////////////
  // Control bundle
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (clr) begin
      memWbWbCtrl.raw <= '0;  // No write, no halt
    end else begin
      memWbWbCtrl.raw <= exMemWbCtrl.raw;  // Moves as a raw word
    end
  end

endmodule

/* logic/memWbTop.sv */
//////////////////////////////
// CPU back end top level
// Arbiter, unified memory, fetch port
// MEM/WB register, write-back stage
//////////////////////////////
`timescale 1ns/1ns

module memWbTop (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush,
  input  logic                            exMemRead,       // Load strobe
  input  logic                            exMemWrite,      // Store strobe
  input  logic                            fetchReq,
  input  logic [cpuPkg::dataWidth-1:0]    exMemPcNext,
  input  logic [cpuPkg::dataWidth-1:0]    exMemAluOut,     // Also the data address
  input  logic [cpuPkg::dataWidth-1:0]    exMemStoreData,
  input  logic [cpuPkg::dataWidth-1:0]    fetchPc,
  input  logic [cpuPkg::wbCtrlWidth-1:0]  exMemWbCtrl,     // Raw control bundle
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddr1,
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddr2,
  output logic [cpuPkg::dataWidth-1:0]    fetchInstr,
  output logic [cpuPkg::dataWidth-1:0]    wbData,
  output logic [cpuPkg::dataWidth-1:0]    rdData1,
  output logic [cpuPkg::dataWidth-1:0]    rdData2,
  output logic                            fetchValid,
  output logic                            fetchStall,
  output logic                            wbWrite,
  output logic                            halted,
  output logic [cpuPkg::regAddrWidth-1:0] wbRegAddr
);

  memPortIf dataPort ();   // Memory stage access
  memPortIf instrPort ();  // Fetch access

  logic                            memWe;
  logic [cpuPkg::memAddrWidth-1:0] memAddr;
  logic [cpuPkg::dataWidth-1:0]    memWrData;
  logic [cpuPkg::dataWidth-1:0]    memRdData;
  logic [cpuPkg::dataWidth-1:0]    memWbPcNext, memWbAluOut, memWbMemData;
  cpuPkg::wbCtrlT                  exMemCtrl, memWbWbCtrl;

  //////////////////////////////
  // Data port tie-in
  //////////////////////////////
  assign dataPort.req    = exMemRead | exMemWrite;
  assign dataPort.we     = exMemWrite;
  assign dataPort.addr   = exMemAluOut;
  assign dataPort.wrData = exMemStoreData;
  assign exMemCtrl.raw   = exMemWbCtrl;  // Plain port into the union

  memArbiter uArbiter (.clk, .dataPort(dataPort), .instrPort(instrPort),
                       .memWe, .memAddr, .memWrData, .memRdData);

  unifiedMemory uMemory (.clk, .we(memWe), .addr(memAddr), .wrData(memWrData),
                         .rdData(memRdData));

  fetchPort uFetch (.clk, .rst, .fetchReq, .fetchPc, .port(instrPort),
                    .fetchInstr, .fetchValid, .fetchStall);

  // Load word comes back on the data port in the same cycle
  memWbPipeReg uMemWb (.clk, .rst, .flush, .exMemPcNext, .exMemAluOut,
                       .memData(dataPort.rdData), .exMemWbCtrl(exMemCtrl),
                       .memWbPcNext, .memWbAluOut, .memWbMemData, .memWbWbCtrl);

  writeBack uWb (.clk, .rst, .memWbPcNext, .memWbAluOut, .memWbMemData, .memWbWbCtrl,
                 .rdAddr1, .rdAddr2, .rdData1, .rdData2, .wbData, .wbRegAddr,
                 .wbWrite, .halted);

endmodule

/* logic/unifiedMemory.sv */
//////////////////////////////
// Unified instruction and data memory
// Combinational read, clocked write
//////////////////////////////
`timescale 1ns/1ns

module unifiedMemory (
  input  logic                            clk,
  input  logic                            we,      // Write strobe from arbiter
  input  logic [cpuPkg::memAddrWidth-1:0] addr,    // Word address
  input  logic [cpuPkg::dataWidth-1:0]    wrData,  // Word to store
  output logic [cpuPkg::dataWidth-1:0]    rdData   // Word at addr, same cycle
);

  logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];  // Storage array

  //////////////////////////////
  // Initial contents
  //////////////////////////////
  // Whole memory starts cleared
  initial begin
    for (int i = 0; i < cpuPkg::memDepth; i++) begin
      mem[i] = '0;
    end
  end

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wrData;  // Lands at end of granted cycle
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////
  // No wait states, answer in the same cycle
  assign rdData = mem[addr];

endmodule

/* logic/writeBack.sv */
//////////////////////////////
// Write-back stage
// Source select and write strobe
// Register file, two read ports
// Sticky halt latch
//////////////////////////////
`timescale 1ns/1ns

module writeBack (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [cpuPkg::dataWidth-1:0]    memWbPcNext,
  input  logic [cpuPkg::dataWidth-1:0]    memWbAluOut,
  input  logic [cpuPkg::dataWidth-1:0]    memWbMemData,
  input  cpuPkg::wbCtrlT                  memWbWbCtrl,
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddr1,    // Decode read port 1
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddr2,    // Decode read port 2
  output logic [cpuPkg::dataWidth-1:0]    rdData1,
  output logic [cpuPkg::dataWidth-1:0]    rdData2,
  output logic [cpuPkg::dataWidth-1:0]    wbData,     // Forwarding bus data
  output logic [cpuPkg::regAddrWidth-1:0] wbRegAddr,  // Forwarding bus register
  output logic                            wbWrite,    // Forwarding bus strobe
  output logic                            halted      // High from halt until reset
);

  cpuPkg::wbFieldsT ctrl;  // Decoded view of the bundle

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];  // Register file

  assign ctrl = memWbWbCtrl.fields;

  //////////////////////////////
  // Source select
  //////////////////////////////
  always_comb begin
    if (ctrl.pcs) begin
      wbData = memWbPcNext;  // Link value
    end else if (ctrl.memToReg) begin
      wbData = memWbMemData;  // Load
    end else begin
      wbData = memWbAluOut;
    end
  end

  assign wbRegAddr = ctrl.regRd;
  assign wbWrite   = ctrl.regWrite & (ctrl.regRd != '0);  // R0 is hardwired

  //////////////////////////////
  // Register file
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (wbWrite) begin
      regs[wbRegAddr] <= wbData;
    end
  end

  // No bypass, a write shows up after the edge
  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

  // Halt latch, set one edge after the bundle arrives
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (ctrl.hlt) begin
      halted <= 1'b1;
    end
  end

  // Decode never sends a link and a load to the same register write
  assert property (@(posedge clk) disable iff (rst)
                   ctrl.regWrite |-> !(ctrl.pcs && ctrl.memToReg))
    else $error("writeBack: pcs and memToReg both set on a register write");

endmodule

/* verif/memWbTb.sv */
//////////////////////////////
// Testbench for the CPU back end
// Memory, MEM/WB and register models
// Directed and random stimulus
// Output assertions, watchdog, report
//////////////////////////////
`timescale 1ns/1ns

module memWbTb;

  localparam int directedCycles = 60;
  localparam int randomCycles   = 200;
  localparam int marginCycles   = 60;

  logic        clk = 1'b0;
  logic        rst, flush, exMemRead, exMemWrite, fetchReq;
  logic [15:0] exMemPcNext, exMemAluOut, exMemStoreData, fetchPc;
  logic [7:0]  exMemWbCtrl;
  logic [3:0]  rdAddr1, rdAddr2, wbRegAddr;
  logic [15:0] fetchInstr, wbData, rdData1, rdData2;
  logic        fetchValid, fetchStall, wbWrite, halted;

  int mismatches = 0;
  int otherErrors = 0;

  memWbTop UUT (.*);

  always #4 clk = ~clk;  // 8 ns period

  //////////////////////////////
  // Reference models
  //////////////////////////////
  logic [15:0]    refMem [256];  // Unified memory, starts cleared
  logic [15:0]    refRegs [16];
  logic [15:0]    regKnown;     // Register written at least once
  logic [15:0]    mPc, mAlu, mMem, refFetchInstr;
  cpuPkg::wbCtrlT mCtrl;        // Modeled MEM/WB bundle
  logic           refHalted, refFetchValid;
  logic [15:0]    expWbData, expRd1, expRd2;
  logic           expWbWrite, expStall, dataReq;

  initial begin
    for (int i = 0; i < 256; i++) begin
      refMem[i] = 16'h0000;
    end
    regKnown = 16'h0001;  // R0 always reads zero
  end

  assign dataReq    = exMemRead | exMemWrite;
  assign expStall   = fetchReq & dataReq;  // Data port wins
  assign expWbData  = mCtrl.fields.pcs ? mPc : (mCtrl.fields.memToReg ? mMem : mAlu);
  assign expWbWrite = mCtrl.fields.regWrite && (mCtrl.fields.regRd != 4'd0);
  assign expRd1     = (rdAddr1 == 4'd0) ? 16'h0000 : refRegs[rdAddr1];
  assign expRd2     = (rdAddr2 == 4'd0) ? 16'h0000 : refRegs[rdAddr2];

  always @(posedge clk) begin
    if (expWbWrite === 1'b1) begin  // Register write one edge after MEM/WB
      refRegs[mCtrl.fields.regRd]  <= expWbData;
      regKnown[mCtrl.fields.regRd] <= 1'b1;
    end
    if (exMemWrite && !rst) begin
      refMem[exMemAluOut[7:0]] <= exMemStoreData;
    end
    if (fetchReq && !dataReq) begin
      refFetchInstr <= refMem[fetchPc[7:0]];
    end
    if (rst) begin
      mPc <= '0;
      mAlu <= '0;
      mMem <= '0;
      mCtrl.raw <= '0;
      refHalted <= 1'b0;
      refFetchValid <= 1'b0;
    end else begin
      mPc <= exMemPcNext;  // Kept on flush
      mAlu <= flush ? 16'h0000 : exMemAluOut;
      mMem <= flush ? 16'h0000 : refMem[exMemAluOut[7:0]];
      mCtrl.raw <= flush ? 8'h00 : exMemWbCtrl;
      refFetchValid <= fetchReq & ~dataReq;
      if (mCtrl.fields.hlt) begin
        refHalted <= 1'b1;  // Sticky
      end
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////
  task automatic reportMismatch(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
    mismatches++;
    $display("MISMATCH %s got %h expected %h at %0t ns", name, got, exp, $time);
  endtask

  assert property (@(posedge clk) disable iff (rst) wbData == expWbData)
    else reportMismatch("wbData", $sampled(wbData), $sampled(expWbData));
  assert property (@(posedge clk) disable iff (rst) wbWrite == expWbWrite)
    else reportMismatch("wbWrite", $sampled(wbWrite), $sampled(expWbWrite));
  assert property (@(posedge clk) disable iff (rst) wbRegAddr == mCtrl.fields.regRd)
    else reportMismatch("wbRegAddr", $sampled(wbRegAddr), $sampled(mCtrl.fields.regRd));
  assert property (@(posedge clk) disable iff (rst) regKnown[rdAddr1] |-> rdData1 == expRd1)
    else reportMismatch("rdData1", $sampled(rdData1), $sampled(expRd1));
  assert property (@(posedge clk) disable iff (rst) regKnown[rdAddr2] |-> rdData2 == expRd2)
    else reportMismatch("rdData2", $sampled(rdData2), $sampled(expRd2));
  assert property (@(posedge clk) disable iff (rst) fetchStall == expStall)
    else reportMismatch("fetchStall", $sampled(fetchStall), $sampled(expStall));
  assert property (@(posedge clk) disable iff (rst) fetchValid == refFetchValid)
    else reportMismatch("fetchValid", $sampled(fetchValid), $sampled(refFetchValid));
  assert property (@(posedge clk) disable iff (rst) fetchValid |-> fetchInstr == refFetchInstr)
    else reportMismatch("fetchInstr", $sampled(fetchInstr), $sampled(refFetchInstr));
  assert property (@(posedge clk) disable iff (rst) halted == refHalted)
    else reportMismatch("halted", $sampled(halted), $sampled(refHalted));
  // Next PC register is internal, seen through the top level wire
  assert property (@(posedge clk) disable iff (rst) UUT.memWbPcNext == mPc)
    else reportMismatch("memWbPcNext", $sampled(UUT.memWbPcNext), $sampled(mPc));

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  function automatic logic [7:0] makeCtrl(input logic [3:0] rd, input logic regWr,
                                          input logic memRd, input logic halt,
                                          input logic link);
    cpuPkg::wbCtrlT c;
    c.fields.regRd    = rd;
    c.fields.regWrite = regWr;
    c.fields.memToReg = memRd;
    c.fields.hlt      = halt;
    c.fields.pcs      = link;
    return c.raw;
  endfunction

  // One EX/MEM input cycle, applied on the falling edge
  task automatic driveCycle(input logic ld, input logic st, input logic fl,
                            input logic [7:0] ctrl, input logic [15:0] pc,
                            input logic [15:0] alu, input logic [15:0] store);
    @(negedge clk);
    exMemRead      = ld;
    exMemWrite     = st;
    flush          = fl;
    exMemWbCtrl    = ctrl;
    exMemPcNext    = pc;
    exMemAluOut    = alu;
    exMemStoreData = store;
  endtask

  task automatic idleCycle();
    driveCycle(1'b0, 1'b0, 1'b0, 8'h00, 16'h0000, 16'h0000, 16'h0000);
  endtask

  // Hold the fetch until its valid pulse shows, then drop it
  task automatic awaitFetch(input int limit);
    int  n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(negedge clk);
      n++;
      if (fetchValid) begin
        seen     = 1'b1;
        fetchReq = 1'b0;
      end
    end
    if (!seen) begin
      otherErrors++;
      $display("Fetch at %h was not delivered within %0d cycles", fetchPc, limit);
      fetchReq = 1'b0;
    end
  endtask

  task automatic randomCycle();
    int          op;
    logic [3:0]  rd;
    logic [15:0] pc, alu, store;
    logic        fl;
    op    = $urandom % 4;
    rd    = $urandom % 16;
    pc    = $urandom;
    alu   = $urandom & 16'hF01F;  // Few words so loads hit earlier stores
    store = $urandom;
    fl    = ($urandom % 8) == 0;
    case (op)
      0: driveCycle(1'b0, 1'b0, fl, makeCtrl(rd, 1'b1, 1'b0, 1'b0, 1'b0), pc, alu, store);
      1: driveCycle(1'b0, 1'b1, fl, makeCtrl(rd, 1'b0, 1'b0, 1'b0, 1'b0), pc, alu, store);
      2: driveCycle(1'b1, 1'b0, fl, makeCtrl(rd, 1'b1, 1'b1, 1'b0, 1'b0), pc, alu, store);
      default: driveCycle(1'b0, 1'b0, fl, makeCtrl(rd, 1'b1, 1'b0, 1'b0, 1'b1), pc, alu, store);
    endcase
    fetchReq = $urandom % 2;
    fetchPc  = $urandom & 16'h00FF;
    rdAddr1  = $urandom % 16;
    rdAddr2  = $urandom % 16;
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////
  initial begin
    #((directedCycles + randomCycles + marginCycles) * 8);
    $display("Watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int seedVal;
    seedVal = $urandom(74);
    rst = 1'b1;
    flush = 1'b0;
    exMemRead = 1'b0;
    exMemWrite = 1'b0;
    fetchReq = 1'b0;
    exMemPcNext = '0;
    exMemAluOut = '0;
    exMemStoreData = '0;
    fetchPc = '0;
    exMemWbCtrl = '0;
    rdAddr1 = '0;
    rdAddr2 = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // ALU write, then write to R0
    driveCycle(1'b0, 1'b0, 1'b0, makeCtrl(4'd5, 1'b1, 1'b0, 1'b0, 1'b0), 16'h0002, 16'h1234, 0);
    rdAddr1 = 4'd5;
    driveCycle(1'b0, 1'b0, 1'b0, makeCtrl(4'd0, 1'b1, 1'b0, 1'b0, 1'b0), 16'h0004, 16'h5555, 0);
    repeat (2) idleCycle();
    // Store then load through an aliased address
    driveCycle(1'b0, 1'b1, 1'b0, 8'h00, 16'h0006, 16'h0040, 16'hBEEF);
    idleCycle();
    driveCycle(1'b1, 1'b0, 1'b0, makeCtrl(4'd6, 1'b1, 1'b1, 1'b0, 1'b0), 16'h0008, 16'h1040, 0);
    rdAddr1 = 4'd6;
    repeat (2) idleCycle();
    // Link value and flush
    driveCycle(1'b0, 1'b0, 1'b0, makeCtrl(4'd7, 1'b1, 1'b0, 1'b0, 1'b1), 16'h0ABC, 16'h7777, 0);
    driveCycle(1'b0, 1'b0, 1'b1, makeCtrl(4'd9, 1'b1, 1'b0, 1'b0, 1'b0), 16'h0111, 16'h2222, 0);
    idleCycle();
    // Fetch alone, then behind a load and a store
    fetchReq = 1'b1;
    fetchPc  = 16'h0040;
    awaitFetch(8);
    driveCycle(1'b1, 1'b0, 1'b0, makeCtrl(4'd10, 1'b1, 1'b1, 1'b0, 1'b0), 16'h0, 16'h0040, 0);
    fetchReq = 1'b1;
    fetchPc  = 16'h0041;
    driveCycle(1'b0, 1'b1, 1'b0, 8'h00, 16'h0000, 16'h0041, 16'h0F0F);
    idleCycle();
    awaitFetch(8);
    repeat (randomCycles) randomCycle();
    fetchReq = 1'b0;
    // Halt, sticky through later traffic, cleared by reset
    driveCycle(1'b0, 1'b0, 1'b0, makeCtrl(4'd8, 1'b1, 1'b0, 1'b1, 1'b0), 16'h0C00, 16'h0808, 0);
    repeat (4) randomCycle();
    fetchReq = 1'b0;
    // Live next PC and bundle presented while reset is high
    driveCycle(1'b0, 1'b0, 1'b0, makeCtrl(4'd3, 1'b1, 1'b0, 1'b0, 1'b0), 16'h0F00, 16'h3333, 0);
    rst = 1'b1;
    idleCycle();
    rst = 1'b0;
    repeat (3) idleCycle();
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
